// ==== design/opm_reg_pkg.sv ====
package opm_reg_pkg;

    // register map of the chip bus
    localparam logic [7:0] REG_KEYON      = 8'h08;
    localparam logic [7:0] REG_TA_HI      = 8'h10; // timer A bits 9..2
    localparam logic [7:0] REG_TA_LO      = 8'h11; // timer A bits 1..0
    localparam logic [7:0] REG_TB         = 8'h12;
    localparam logic [7:0] REG_TIMER_CTRL = 8'h14;
    localparam logic [7:0] REG_CT         = 8'h1B; // bit 6 ct1, bit 7 ct2

    // per channel banks, channel in the low three address bits
    localparam logic [7:0] REG_RL_BASE    = 8'h20; // bit 6 left, bit 7 right
    localparam logic [7:0] REG_FHI_BASE   = 8'h28; // increment high byte
    localparam logic [7:0] REG_FLO_BASE   = 8'h30; // increment low byte

    // key-on byte
    typedef struct packed {
        logic       unused;
        logic [3:0] mask;   // any bit set keys the channel on
        logic [2:0] ch;
    } keyon_t;

    // timer control byte
    typedef struct packed {
        logic [1:0] unused;
        logic       clr_b;
        logic       clr_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;
        logic       load_a;
    } timer_ctrl_t;

    // one data byte, read through whichever view the address selects
    typedef union packed {
        keyon_t      keyon;
        timer_ctrl_t tctrl;
    } reg_data_u;

    typedef struct packed {
        logic       busy;
        logic [4:0] zeros;
        logic       flag_b;
        logic       flag_a;
    } status_t;

endpackage

// ==== design/opm_frame_pkg.sv ====
package opm_frame_pkg;

    // cen ticks per sample frame
    localparam int SLOT_COUNT = 32;

    // frames per timer B count
    localparam int TIMER_B_PRESCALE = 16;

    localparam int CH_COUNT = 8;

    typedef logic [2:0] chan_t;

    // signed audio sample at the outputs
    typedef logic signed [15:0] sample_t;

endpackage

// ==== design/opm_frame_seq.sv ====
`timescale 1ns/1ps

module opm_frame_seq
    import opm_frame_pkg::*;
(
    input  logic zero,
    input  logic rst_n,
    input  logic cen,
    output logic frame_start,
    output logic half_start
);

    localparam int SLOT_W = $clog2(SLOT_COUNT);

    logic [SLOT_W-1:0] slot;

    always_ff @(posedge zero) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (cen) begin
            if (slot == SLOT_W'(SLOT_COUNT - 1)) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // strobes last the single cen clock of their slot
    assign frame_start = cen && (slot == '0);
    assign half_start  = cen && (slot == SLOT_W'(SLOT_COUNT / 2));

endmodule

// ==== design/opm_mmr.sv ====
`timescale 1ns/1ps

module opm_mmr
    import opm_reg_pkg::*, opm_frame_pkg::*;
(
    input  logic                zero,
    input  logic                rst_n,
    input  logic                cen,
    input  logic                half_start, // half-frame strobe from the sequencer
    input  logic                write,
    input  logic                a0,
    input  logic [7:0]          din,
    output logic                busy,
    output logic                ct1,
    output logic                ct2,
    output logic [9:0]          value_a,
    output logic [7:0]          value_b,
    output logic                load_a,
    output logic                load_b,
    output logic                irq_en_a,
    output logic                irq_en_b,
    output logic                clr_a,
    output logic                clr_b,
    output logic [CH_COUNT-1:0] key_on,
    output logic [CH_COUNT-1:0] rl_left,
    output logic [CH_COUNT-1:0] rl_right,
    output logic                freq_we,
    output chan_t               freq_ch,
    output logic [15:0]         freq_value
);

    logic [7:0] addr;              // latched register address
    logic [7:0] fhi [CH_COUNT];    // increment high bytes, wait for the low byte
    reg_data_u  data_u;
    logic       data_we;
    chan_t      reg_ch;
    logic       busy_half;         // first half-frame boundary seen

    assign data_u  = din;
    assign data_we = write && a0;
    assign reg_ch  = addr[2:0];

    always_ff @(posedge zero) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (write && !a0) begin
            addr <= din;
        end
    end

    // control state and one-clock strobes
    always_ff @(posedge zero) begin
        if (!rst_n) begin
            ct1      <= 1'b0;
            ct2      <= 1'b0;
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
            clr_a    <= 1'b0;
            clr_b    <= 1'b0;
            key_on   <= '0;
            freq_we  <= 1'b0;
        end else begin
            clr_a   <= 1'b0;
            clr_b   <= 1'b0;
            freq_we <= 1'b0;
            if (data_we) begin
                case (addr)
                    REG_TIMER_CTRL: begin
                        load_a   <= data_u.tctrl.load_a;
                        load_b   <= data_u.tctrl.load_b;
                        irq_en_a <= data_u.tctrl.irq_en_a;
                        irq_en_b <= data_u.tctrl.irq_en_b;
                        clr_a    <= data_u.tctrl.clr_a;
                        clr_b    <= data_u.tctrl.clr_b;
                    end
                    REG_KEYON: key_on[data_u.keyon.ch] <= |data_u.keyon.mask;
                    REG_CT: begin
                        ct1 <= din[6];
                        ct2 <= din[7];
                    end
                    default: ;
                endcase
                if (addr[7:3] == REG_FLO_BASE[7:3]) freq_we <= 1'b1;
            end
        end
    end

    // register file payload
    always_ff @(posedge zero) begin
        if (data_we) begin
            case (addr)
                REG_TA_HI: value_a[9:2] <= din;
                REG_TA_LO: value_a[1:0] <= din[1:0];
                REG_TB:    value_b      <= din;
                default: ;
            endcase
            if (addr[7:3] == REG_RL_BASE[7:3]) begin
                rl_left[reg_ch]  <= din[6];
                rl_right[reg_ch] <= din[7];
            end
            if (addr[7:3] == REG_FHI_BASE[7:3]) fhi[reg_ch] <= din;
            if (addr[7:3] == REG_FLO_BASE[7:3]) begin
                freq_ch    <= reg_ch;
                freq_value <= {fhi[reg_ch], din}; // low byte commits the increment
            end
        end
    end

    // busy drops at the end of the second half-frame after the last write
    always_ff @(posedge zero) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            busy_half <= 1'b0;
        end else if (data_we) begin
            busy      <= 1'b1;
            busy_half <= 1'b0;
        end else if (busy && cen && half_start) begin
            busy_half <= 1'b1;
            if (busy_half) busy <= 1'b0;
        end
    end

endmodule

// ==== design/opm_timers.sv ====
`timescale 1ns/1ps

module opm_timers
    import opm_frame_pkg::*;
(
    input  logic       zero,
    input  logic       rst_n,
    input  logic       cen,
    input  logic       frame_start,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       irq_en_a,
    input  logic       irq_en_b,
    input  logic       clr_a,
    input  logic       clr_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    localparam int PRE_W = $clog2(TIMER_B_PRESCALE);

    logic [9:0]       cnt_a;
    logic [7:0]       cnt_b;
    logic [PRE_W-1:0] pre_b;     // frame prescaler for timer B
    logic             load_a_q;
    logic             load_b_q;
    logic             tick;

    assign tick = cen && frame_start;

    always_ff @(posedge zero) begin
        if (!rst_n) begin
            cnt_a    <= '0;
            cnt_b    <= '0;
            pre_b    <= '0;
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
            flag_a   <= 1'b0;
            flag_b   <= 1'b0;
        end else begin
            load_a_q <= load_a;
            load_b_q <= load_b;
            if (clr_a) flag_a <= 1'b0;
            if (clr_b) flag_b <= 1'b0;

            if (load_a && !load_a_q) begin
                cnt_a <= value_a;   // start from the programmed value
            end else if (load_a && tick) begin
                if (&cnt_a) begin
                    cnt_a  <= value_a;
                    flag_a <= 1'b1;
                end else begin
                    cnt_a <= cnt_a + 10'd1;
                end
            end

            if (load_b && !load_b_q) begin
                cnt_b <= value_b;
                pre_b <= '0;
            end else if (load_b && tick) begin
                pre_b <= pre_b + 1'b1;  // wraps at TIMER_B_PRESCALE
                if (pre_b == PRE_W'(TIMER_B_PRESCALE - 1)) begin
                    if (&cnt_b) begin
                        cnt_b  <= value_b;
                        flag_b <= 1'b1;
                    end else begin
                        cnt_b <= cnt_b + 8'd1;
                    end
                end
            end
        end
    end

    assign irq_n = !((flag_a && irq_en_a) || (flag_b && irq_en_b));

endmodule

// ==== design/opm_tone.sv ====
`timescale 1ns/1ps

module opm_tone
    import opm_frame_pkg::*;
#(
    parameter int PHASE_W = 16
) (
    input  logic                zero,
    input  logic                rst_n,
    input  logic                frame_start,
    input  logic [CH_COUNT-1:0] key_on,
    input  logic [CH_COUNT-1:0] rl_left,
    input  logic [CH_COUNT-1:0] rl_right,
    input  logic                freq_we,
    input  chan_t               freq_ch,
    input  logic [15:0]         freq_value,
    output sample_t             left,
    output sample_t             right
);

    logic [15:0]         inc   [CH_COUNT];
    logic [PHASE_W-1:0]  phase [CH_COUNT];
    logic signed [11:0]  saw   [CH_COUNT];
    sample_t             mix_l;
    sample_t             mix_r;

    always_ff @(posedge zero) begin
        if (freq_we) inc[freq_ch] <= freq_value;
    end

    always_ff @(posedge zero) begin
        for (int i = 0; i < CH_COUNT; i++) begin
            if (!rst_n || !key_on[i]) begin
                phase[i] <= '0;             // keyed off channels sit at zero
            end else if (frame_start) begin
                phase[i] <= phase[i] + PHASE_W'(inc[i]);
            end
        end
    end

    // sawtooth from the top phase bits, summed per side
    always_comb begin
        mix_l = '0;
        mix_r = '0;
        for (int i = 0; i < CH_COUNT; i++) begin
            saw[i] = phase[i][PHASE_W-1 -: 12];
            if (key_on[i] && rl_left[i])  mix_l = mix_l + {{4{saw[i][11]}}, saw[i]};
            if (key_on[i] && rl_right[i]) mix_r = mix_r + {{4{saw[i][11]}}, saw[i]};
        end
    end

    // sampled from the phases before this frame's update
    always_ff @(posedge zero) begin
        if (!rst_n) begin
            left  <= '0;
            right <= '0;
        end else if (frame_start) begin
            left  <= mix_l;
            right <= mix_r;
        end
    end

endmodule

// ==== design/opm_top.sv ====
`timescale 1ns/1ps

module opm_top
    import opm_reg_pkg::*, opm_frame_pkg::*;
#(
    parameter int PHASE_W = 16
) (
    input  logic       zero,
    input  logic       rst_n,
    input  logic       cen,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic       a0,
    input  logic [7:0] din,
    output status_t    dout,
    output logic       ct1,
    output logic       ct2,
    output logic       irq_n,
    output logic       sample,
    output sample_t    left,
    output sample_t    right
);

    logic                write;
    logic                frame_start;
    logic                half_start;
    logic                busy;
    logic [9:0]          value_a;
    logic [7:0]          value_b;
    logic                load_a, load_b;
    logic                irq_en_a, irq_en_b;
    logic                clr_a, clr_b;
    logic                flag_a, flag_b;
    logic [CH_COUNT-1:0] key_on;
    logic [CH_COUNT-1:0] rl_left, rl_right;
    logic                freq_we;
    chan_t               freq_ch;
    logic [15:0]         freq_value;

    assign write  = !cs_n && !wr_n;
    assign sample = frame_start;    // one pulse per output sample

    assign dout = '{busy: busy, zeros: 5'd0, flag_b: flag_b, flag_a: flag_a};

    opm_frame_seq u_frame_seq (
        .zero        (zero),
        .rst_n       (rst_n),
        .cen         (cen),
        .frame_start (frame_start),
        .half_start  (half_start)
    );

    opm_mmr u_mmr (
        .zero       (zero),       .rst_n      (rst_n),      .cen        (cen),
        .half_start (half_start), .write      (write),      .a0         (a0),
        .din        (din),        .busy       (busy),       .ct1        (ct1),
        .ct2        (ct2),        .value_a    (value_a),    .value_b    (value_b),
        .load_a     (load_a),     .load_b     (load_b),     .irq_en_a   (irq_en_a),
        .irq_en_b   (irq_en_b),   .clr_a      (clr_a),      .clr_b      (clr_b),
        .key_on     (key_on),     .rl_left    (rl_left),    .rl_right   (rl_right),
        .freq_we    (freq_we),    .freq_ch    (freq_ch),    .freq_value (freq_value)
    );

    opm_timers u_timers (
        .zero     (zero),     .rst_n    (rst_n),    .cen      (cen),
        .frame_start (frame_start),
        .value_a  (value_a),  .value_b  (value_b),  .load_a   (load_a),
        .load_b   (load_b),   .irq_en_a (irq_en_a), .irq_en_b (irq_en_b),
        .clr_a    (clr_a),    .clr_b    (clr_b),    .flag_a   (flag_a),
        .flag_b   (flag_b),   .irq_n    (irq_n)
    );

    opm_tone #(.PHASE_W(PHASE_W)) u_tone (
        .zero       (zero),       .rst_n      (rst_n),      .frame_start (frame_start),
        .key_on     (key_on),     .rl_left    (rl_left),    .rl_right    (rl_right),
        .freq_we    (freq_we),    .freq_ch    (freq_ch),    .freq_value  (freq_value),
        .left       (left),       .right      (right)
    );

endmodule

// ==== tb/opm_tb_tasks.svh ====
// reference tone model state
logic [15:0]        m_inc   [CH_COUNT];
logic [PHASE_W-1:0] m_phase [CH_COUNT];
bit                 m_on    [CH_COUNT];
bit                 m_l     [CH_COUNT];
bit                 m_r     [CH_COUNT];

task automatic check_status(input status_t got, input status_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0t: %s, status %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0t: %s, sample %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("ERR %0t: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_int(input int got, input int exp, input string what);
    check_count++;
    if (got != exp) begin
        err_count++;
        $display("ERR %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
endtask

function automatic status_t make_status(input bit busy, input bit fb, input bit fa);
    status_t s;
    s        = '0;
    s.busy   = busy;
    s.flag_b = fb;
    s.flag_a = fa;
    return s;
endfunction

function automatic timer_ctrl_t ctrl_byte(input bit clr_b, input bit clr_a, input bit en_b,
                                          input bit en_a, input bit ld_b, input bit ld_a);
    timer_ctrl_t t;
    t          = '0;
    t.clr_b    = clr_b;
    t.clr_a    = clr_a;
    t.irq_en_b = en_b;
    t.irq_en_a = en_a;
    t.load_b   = ld_b;
    t.load_a   = ld_a;
    return t;
endfunction

// address cycle then data cycle, one clock each
task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
    @(negedge zero);
    cs_n = 1'b0;
    wr_n = 1'b0;
    a0   = 1'b0;
    din  = addr;
    @(negedge zero);
    a0  = 1'b1;
    din = data;
    @(negedge zero);
    cs_n = 1'b1;
    wr_n = 1'b1;
    a0   = 1'b0;
    din  = 8'h00;
endtask

// returns on the falling edge after the n-th sample pulse
task automatic wait_frames(input int n);
    int seen;
    int clocks;
    seen   = 0;
    clocks = 0;
    while (seen < n && clocks < (n + 1) * SLOT_COUNT * 2) begin
        @(posedge zero);
        clocks++;
        if (sample === 1'b1) seen++;
    end
    if (seen < n) begin
        err_count++;
        $display("timeout: only %0d of %0d sample pulses arrived", seen, n);
    end
    @(negedge zero);
endtask

task automatic wait_not_busy();
    int clocks;
    clocks = 0;
    while (dout.busy !== 1'b0 && clocks < 4 * SLOT_COUNT * 2) begin
        @(negedge zero);
        clocks++;
    end
    if (dout.busy !== 1'b0) begin
        err_count++;
        $display("timeout: busy never dropped after a register write");
    end
endtask

task automatic wait_flag(input bit timer_b, input int max_frames, output int frames,
                         output bit irq_fell);
    int clocks;
    bit seen;
    frames   = 0;
    clocks   = 0;
    seen     = 0;
    irq_fell = 0;
    while (!seen && frames <= max_frames && clocks < (max_frames + 2) * SLOT_COUNT * 2) begin
        @(posedge zero);
        clocks++;
        if (sample === 1'b1) frames++;
        if (irq_n !== 1'b1) irq_fell = 1;
        seen = timer_b ? dout.flag_b : dout.flag_a;
    end
    if (!seen) begin
        err_count++;
        $display("timeout: timer %s flag not set within %0d frames", timer_b ? "B" : "A",
                 max_frames);
    end
endtask

task automatic set_key(input chan_t ch, input bit on);
    keyon_t kv;
    kv.unused = 1'b0;
    kv.mask   = on ? 4'hF : 4'h0;
    kv.ch     = ch;
    bus_write(REG_KEYON, kv);
    m_on[ch]    = on;
    m_phase[ch] = '0;   // phase sits at zero while keyed off
endtask

function automatic sample_t model_side(input bit right_side);
    sample_t            sum;
    logic signed [11:0] saw;
    sum = '0;
    for (int c = 0; c < CH_COUNT; c++) begin
        saw = m_phase[c][PHASE_W-1 -: 12];
        if (m_on[c] && (right_side ? m_r[c] : m_l[c])) sum = sum + saw;
    end
    return sum;
endfunction

// outputs come from the phases held before each pulse
task automatic check_audio_frames(input int n);
    for (int k = 0; k < n; k++) begin
        wait_frames(1);
        check_sample(left, model_side(1'b0), "left output");
        check_sample(right, model_side(1'b1), "right output");
        for (int c = 0; c < CH_COUNT; c++) begin
            if (m_on[c]) m_phase[c] = m_phase[c] + PHASE_W'(m_inc[c]);
        end
    end
endtask

// ==== tb/tb_opm.sv ====
`timescale 1ns/1ps

module tb_opm
    import opm_reg_pkg::*, opm_frame_pkg::*;
();

    localparam int PHASE_W = 16;

    logic       zero = 1'b0;
    logic       cen  = 1'b0;
    logic       rst_n;
    logic       cs_n;
    logic       wr_n;
    logic       a0;
    logic [7:0] din;
    status_t    dout;
    logic       ct1;
    logic       ct2;
    logic       irq_n;
    logic       sample;
    sample_t    left;
    sample_t    right;

    int check_count = 0;
    int err_count   = 0;

    `include "opm_tb_tasks.svh"

    opm_top #(.PHASE_W(PHASE_W)) DUT (
        .zero  (zero),  .rst_n (rst_n), .cen   (cen),
        .cs_n  (cs_n),  .wr_n  (wr_n),  .a0    (a0),
        .din   (din),   .dout  (dout),  .ct1   (ct1),
        .ct2   (ct2),   .irq_n (irq_n), .sample (sample),
        .left  (left),  .right (right)
    );

    always #4 zero = ~zero;

    always @(negedge zero) cen <= !cen;  // high on every second clock

    task automatic report_test(input string name, input int errs_at_start);
        $display("%-10s finished, %0d errors", name, err_count - errs_at_start);
    endtask

    task automatic test_reset();
        int e0;
        int ticks;
        int pulses;
        int clocks;
        e0     = err_count;
        ticks  = 0;
        pulses = 0;
        clocks = 0;
        check_status(dout, make_status(0, 0, 0), "status after reset");
        check_bit(irq_n, 1'b1, "irq_n after reset");
        check_bit(ct1, 1'b0, "ct1 after reset");
        check_bit(ct2, 1'b0, "ct2 after reset");
        check_sample(left, 16'sd0, "left after reset");
        check_sample(right, 16'sd0, "right after reset");
        while (pulses <= 3 && clocks < 5 * SLOT_COUNT * 2) begin
            @(posedge zero);
            clocks++;
            if (cen) ticks++;
            if (sample === 1'b1) begin
                if (pulses > 0) check_int(ticks, SLOT_COUNT, "cen ticks between pulses");
                pulses++;
                ticks = 0;
            end
        end
        if (pulses <= 3) begin
            err_count++;
            $display("timeout: sample pulses stopped after %0d", pulses);
        end
        @(negedge zero);
        report_test("reset", e0);
    endtask

    task automatic test_busy_ct();
        int e0;
        e0 = err_count;
        bus_write(REG_CT, 8'hC0);
        check_status(dout, make_status(1, 0, 0), "busy after CT write");
        wait_not_busy();
        check_status(dout, make_status(0, 0, 0), "busy released");
        check_bit(ct1, 1'b1, "ct1 set");
        check_bit(ct2, 1'b1, "ct2 set");
        bus_write(REG_CT, 8'h40);
        check_bit(ct1, 1'b1, "ct1 kept");
        check_bit(ct2, 1'b0, "ct2 dropped");
        bus_write(REG_CT, 8'h00);
        check_bit(ct1, 1'b0, "ct1 restored");
        check_bit(ct2, 1'b0, "ct2 restored");
        wait_not_busy();
        report_test("busy_ct", e0);
    endtask

    task automatic test_timer_a();
        int         e0;
        int         period;
        int         frames;
        bit         irq_fell;
        logic [9:0] va;
        e0     = err_count;
        va     = 10'd1023 - 10'($urandom % 8);
        period = 1024 - va;
        bus_write(REG_TA_HI, va[9:2]);
        bus_write(REG_TA_LO, {6'd0, va[1:0]});
        bus_write(REG_TIMER_CTRL, ctrl_byte(0, 0, 0, 1, 0, 1));
        wait_flag(1'b0, period + 2, frames, irq_fell);
        check_bit(irq_fell, 1'b1, "irq_n fell with flag_a");
        check_bit(frames >= period, 1'b1, "timer A flag not early");
        @(negedge zero);
        check_bit(irq_n, 1'b0, "irq_n with flag_a enabled");
        wait_not_busy();
        check_status(dout, make_status(0, 0, 1), "timer A flagged");
        bus_write(REG_TIMER_CTRL, ctrl_byte(0, 1, 0, 1, 0, 0)); // clear and stop
        @(negedge zero);
        check_status(dout, make_status(1, 0, 0), "timer A cleared");
        check_bit(irq_n, 1'b1, "irq_n after clear");
        wait_not_busy();
        report_test("timer_a", e0);
    endtask

    task automatic test_timer_b();
        int         e0;
        int         period;
        int         frames;
        bit         irq_fell;
        logic [7:0] vb;
        e0     = err_count;
        vb     = 8'd255 - 8'($urandom % 2);
        period = TIMER_B_PRESCALE * (256 - vb);
        bus_write(REG_TB, vb);
        bus_write(REG_TIMER_CTRL, ctrl_byte(0, 0, 0, 0, 1, 0));
        wait_flag(1'b1, period + 2, frames, irq_fell);
        check_bit(irq_fell, 1'b0, "irq_n low with irq_en_b off");
        check_bit(frames >= period, 1'b1, "timer B flag not early");
        @(negedge zero);
        check_bit(irq_n, 1'b1, "irq_n with flag_b masked");
        wait_not_busy();
        check_status(dout, make_status(0, 1, 0), "timer B flagged");
        bus_write(REG_TIMER_CTRL, ctrl_byte(1, 0, 0, 0, 0, 0));
        @(negedge zero);
        check_status(dout, make_status(1, 0, 0), "timer B cleared");
        wait_not_busy();
        report_test("timer_b", e0);
    endtask

    task automatic test_tone();
        int          e0;
        chan_t       chans [3];
        logic [15:0] inc;
        logic [1:0]  rl;
        e0    = err_count;
        chans = '{3'd1, 3'd4, 3'd6};
        for (int c = 0; c < CH_COUNT; c++) begin
            m_on[c]    = 0;
            m_phase[c] = '0;
            m_l[c]     = 0;
            m_r[c]     = 0;
        end
        for (int i = 0; i < 3; i++) begin
            inc = 16'($urandom);
            rl  = (i == 0) ? 2'b11 : 2'($urandom);
            m_inc[chans[i]] = inc;
            m_l[chans[i]]   = rl[0];
            m_r[chans[i]]   = rl[1];
            bus_write(REG_FHI_BASE + {5'd0, chans[i]}, inc[15:8]);
            bus_write(REG_FLO_BASE + {5'd0, chans[i]}, inc[7:0]);
            bus_write(REG_RL_BASE + {5'd0, chans[i]}, {rl, 6'd0});
        end
        wait_frames(1);     // key-on writes all land inside one frame
        for (int i = 0; i < 3; i++) set_key(chans[i], 1'b1);
        check_audio_frames(6);
        report_test("tone", e0);
    endtask

    task automatic test_key_off();
        int e0;
        e0 = err_count;
        set_key(3'd4, 1'b0);
        check_audio_frames(3);
        set_key(3'd1, 1'b0);
        set_key(3'd6, 1'b0);
        check_audio_frames(2);
        check_sample(left, 16'sd0, "left with all keyed off");
        check_sample(right, 16'sd0, "right with all keyed off");
        report_test("key_off", e0);
    endtask

    initial begin
        void'($urandom(32'h289d_1725));
        rst_n = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        a0    = 1'b0;
        din   = 8'h00;
        repeat (8) @(negedge zero);
        rst_n = 1'b1;
        @(negedge zero);

        test_reset();
        test_busy_ct();
        test_timer_a();
        test_timer_b();
        test_tone();
        test_key_off();

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+tb
design/opm_reg_pkg.sv
design/opm_frame_pkg.sv
design/opm_frame_seq.sv
design/opm_mmr.sv
design/opm_timers.sv
design/opm_tone.sv
design/opm_top.sv
tb/tb_opm.sv
